// ==== compile.f ====
logic/ex_pkg.sv
logic/alu_decoder.sv
logic/alu.sv
logic/operand_forward.sv
logic/store_align.sv
logic/csr_file.sv
logic/ex_stage.sv
tb/ex_stage_asserts.sv
tb/tb_ex_stage.sv

// ==== tb/tb_ex_stage.sv ====
`timescale 1ns/100ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int N_ALU        = 300;
    localparam int N_FWD        = 300;
    localparam int N_STORE      = 200;
    localparam int N_CSR        = 200;
    localparam int N_PIPE       = 300;
    localparam int MAX_CYCLES   = N_ALU + N_FWD + N_STORE + N_CSR + N_PIPE + RESET_CYCLES + 50;

    logic              clk = 1'b0;
    logic              arst_n;
    ex_in_t            ex_in;
    logic              wb_we;
    logic [REG_AW-1:0] wb_addr;
    logic [XLEN-1:0]   wb_data;
    ex_out_t           ex_out;

    logic [31:0] lfsr;
    ex_out_t     exp_q;
    logic [31:0] csr_m [3];
    int          err_count   = 0;
    int          pass_tests  = 0;
    int          fail_tests  = 0;
    int          cycle_count = 0;

    ex_stage dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .ex_in_i   (ex_in),
        .wb_we_i   (wb_we),
        .wb_addr_i (wb_addr),
        .wb_data_i (wb_data),
        .ex_out_o  (ex_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check(input logic [127:0] act, input logic [127:0] exp, input string msg);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, msg, act, exp);
            err_count++;
        end
    endtask

    function automatic ex_in_t gen_instr(input int mode);
        ex_in_t t;
        int     kind;
        kind       = (mode == 5) ? int'(take_bits(2)) + 1 : mode;
        t.valid    = (mode == 5) ? 1'(take_bits(1)) : 1'b1;
        t.pc       = {30'(take_bits(30)), 2'b00};
        t.pc_plus4 = t.pc + 32'd4;
        t.rs1_data = take_bits(32);
        t.rs2_data = take_bits(32);
        t.rs1_addr = 5'(take_bits(5));
        t.rs2_addr = 5'(take_bits(5));
        t.rd_addr  = 5'(take_bits(5));
        t.imm      = take_bits(32);
        t.csr_addr = 12'(take_bits(12));
        t.funct3   = 3'(take_bits(3));
        t.bit30    = 1'(take_bits(1));
        t.alu_op   = alu_op_t'(2'(take_bits(2)));
        t.a_is_pc  = 1'(take_bits(1));
        t.b_is_imm = 1'(take_bits(1));
        t.store    = 1'b0;
        t.csr_we   = 1'b0;
        t.rd_we    = 1'(take_bits(1));
        t.wr_sel   = WR_ALU;
        case (kind)
            2: begin
                // four registers only, so dependences are frequent
                t.rs1_addr = 5'(take_bits(2));
                t.rs2_addr = 5'(take_bits(2));
                t.rd_addr  = 5'(take_bits(2));
                t.a_is_pc  = 1'b0;
                t.b_is_imm = 1'b0;
                t.wr_sel   = wr_sel_t'(2'(take_bits(2)));
            end
            3: begin
                t.store    = 1'b1;
                t.alu_op   = ALU_ADD;
                t.a_is_pc  = 1'b0;
                t.b_is_imm = 1'b1;
                t.imm      = take_bits(4);
                t.funct3   = 3'(take_bits(2));
                t.rd_we    = 1'b0;
            end
            4: begin
                t.csr_we = 1'b1;
                t.rd_we  = 1'b1;
                t.wr_sel = WR_CSR;
                t.imm    = take_bits(5);
                case (2'(take_bits(2)))
                    2'd0:    t.funct3 = 3'b001;
                    2'd1:    t.funct3 = 3'b101;
                    default: t.funct3 = 3'(take_bits(3));
                endcase
                case (2'(take_bits(2)))
                    2'd0:    t.csr_addr = 12'h305;
                    2'd1:    t.csr_addr = 12'h340;
                    2'd2:    t.csr_addr = 12'h341;
                    default: t.csr_addr = 12'(take_bits(12));
                endcase
            end
            default: begin
            end
        endcase
        return t;
    endfunction

    // newest result wins, x0 never forwards, load results are not ready
    function automatic logic [31:0] fwd_model(input logic [4:0] addr, input logic [31:0] reg_val);
        if (addr == 5'd0)
            return reg_val;
        if (exp_q.valid && exp_q.rd_we && exp_q.wr_sel != WR_MEM && addr == exp_q.rd_addr)
            return exp_q.result;
        if (wb_we && addr == wb_addr)
            return wb_data;
        return reg_val;
    endfunction

    function automatic logic [31:0] alu_model(input ex_in_t t, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        if (t.alu_op == ALU_ADD)
            return a + b;
        if (t.alu_op == ALU_PASS_B)
            return b;
        case (t.funct3)
            3'd0: return (t.alu_op == ALU_REG && t.bit30) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (t.bit30)
                    return $signed(a) >>> sh;
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic predict();
        ex_out_t     e;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] res;
        logic [31:0] old;
        logic [1:0]  off;
        int          idx;
        r1  = fwd_model(ex_in.rs1_addr, ex_in.rs1_data);
        r2  = fwd_model(ex_in.rs2_addr, ex_in.rs2_data);
        res = alu_model(ex_in, ex_in.a_is_pc ? ex_in.pc : r1, ex_in.b_is_imm ? ex_in.imm : r2);
        case (ex_in.csr_addr)
            12'h305: idx = 0;
            12'h340: idx = 1;
            12'h341: idx = 2;
            default: idx = 3;
        endcase
        old = (idx < 3) ? csr_m[idx] : 32'd0;
        if (ex_in.valid && ex_in.csr_we && idx < 3) begin
            if (ex_in.funct3 == 3'b001)
                csr_m[idx] = r1;
            else if (ex_in.funct3 == 3'b101)
                csr_m[idx] = ex_in.imm;
        end
        e          = '0;
        e.valid    = ex_in.valid;
        e.result   = (ex_in.wr_sel == WR_CSR) ? old : res;
        e.rd_addr  = ex_in.rd_addr;
        e.rd_we    = ex_in.valid && ex_in.rd_we;
        e.wr_sel   = ex_in.wr_sel;
        e.pc_plus4 = ex_in.pc_plus4;
        off        = res[1:0];
        if (ex_in.valid && ex_in.store) begin
            case (ex_in.funct3)
                3'b000: begin
                    e.byte_en[off] = 1'b1;
                    e.store_data   = {4{r2[7:0]}};
                end
                3'b001: begin
                    e.store_data = {2{r2[15:0]}};
                    if (off[0])
                        e.store_misaligned = 1'b1;
                    else
                        e.byte_en = off[1] ? 4'b1100 : 4'b0011;
                end
                3'b010: begin
                    e.store_data = r2;
                    if (off != 2'b00)
                        e.store_misaligned = 1'b1;
                    else
                        e.byte_en = 4'b1111;
                end
                default: begin
                end
            endcase
        end
        exp_q = e;
    endtask

    task automatic compare_out();
        check(ex_out.valid, exp_q.valid, "valid");
        check(ex_out.rd_we, exp_q.rd_we, "rd_we");
        check(ex_out.rd_addr, exp_q.rd_addr, "rd_addr");
        check(ex_out.wr_sel, exp_q.wr_sel, "wr_sel");
        check(ex_out.byte_en, exp_q.byte_en, "byte_en");
        check(ex_out.store_misaligned, exp_q.store_misaligned, "store_misaligned");
        check(ex_out.pc_plus4, exp_q.pc_plus4, "pc_plus4");
        if (exp_q.valid)
            check(ex_out.result, exp_q.result, "result");
        if (exp_q.byte_en != 4'b0000)
            check(ex_out.store_data, exp_q.store_data, "store_data");
    endtask

    task automatic step(input int mode);
        @(negedge clk);
        compare_out();
        ex_in   = gen_instr(mode);
        wb_we   = 1'(take_bits(1));
        wb_addr = (mode == 2) ? 5'(take_bits(2)) : 5'(take_bits(5));
        wb_data = take_bits(32);
        predict();
    endtask

    // a bubble so the last instruction of a test is checked within it
    task automatic drain();
        @(negedge clk);
        compare_out();
        ex_in = '0;
        wb_we = 1'b0;
        predict();
    endtask

    task automatic clear_model();
        exp_q = '0;
        foreach (csr_m[i])
            csr_m[i] = '0;
    endtask

    task automatic mid_reset();
        @(negedge clk);
        compare_out();
        ex_in  = '0;
        wb_we  = 1'b0;
        arst_n = 1'b0;
        #1;
        check(ex_out, '0, "ex_out_o not cleared by reset");
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        clear_model();
    endtask

    task automatic run_test(input string name, input int mode, input int n);
        int err0;
        err0 = err_count;
        // the pipeline test starts from a reset in mid run
        if (mode == 5)
            mid_reset();
        repeat (n) step(mode);
        drain();
        if (err_count == err0) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_count - err0);
        end
    endtask

    initial begin
        lfsr    = 32'd71648;
        arst_n  = 1'b0;
        ex_in   = '0;
        wb_we   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk);
        check(ex_out, '0, "ex_out_o after reset");
        arst_n = 1'b1;
        run_test("alu decode", 1, N_ALU);
        run_test("forwarding", 2, N_FWD);
        run_test("stores", 3, N_STORE);
        run_test("csr", 4, N_CSR);
        run_test("pipeline and reset", 5, N_PIPE);
        $display("summary: %0d tests passed, %0d failed, %0d checks failed, %0d assertion failures",
                 pass_tests, fail_tests, err_count, dut.u_asserts.fail_count);
        if (fail_tests == 0 && err_count == 0 && dut.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb/ex_stage_asserts.sv ====
`timescale 1ns/100ps

module ex_stage_asserts (
    input logic            clk_i,
    input logic            arst_n_i,
    input ex_pkg::ex_out_t ex_out_i
);

    int fail_count = 0;

    // sampled on the falling edge, away from register updates
    no_lanes_when_invalid: assert property (
        @(negedge clk_i) !ex_out_i.valid |-> ex_out_i.byte_en == 4'b0000)
        else begin
            fail_count++;
            $error("byte enables set on an invalid output");
        end

    no_lanes_when_misaligned: assert property (
        @(negedge clk_i) ex_out_i.store_misaligned |-> ex_out_i.byte_en == 4'b0000)
        else begin
            fail_count++;
            $error("byte enables set on a misaligned store");
        end

    cleared_in_reset: assert property (
        @(negedge clk_i) !arst_n_i |-> ex_out_i == '0)
        else begin
            fail_count++;
            $error("output bundle not cleared during reset");
        end

endmodule

bind ex_stage ex_stage_asserts u_asserts (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ex_out_i (ex_out_o)
);

// ==== logic/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  ex_pkg::ex_in_t            ex_in_i,
    input  logic                      wb_we_i,
    input  logic [ex_pkg::REG_AW-1:0] wb_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   wb_data_i,
    output ex_pkg::ex_out_t           ex_out_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] csr_rdata;
    logic [XLEN-1:0] store_data;
    logic [3:0]      byte_en;
    logic            misaligned;
    logic            csr_wr;
    alu_ctrl_t       alu_ctrl;
    ex_out_t         ex_next;

    // ex_out_o doubles as the ex/mem forwarding source
    operand_forward u_operand_forward (
        .ex_in_i   (ex_in_i),
        .exmem_i   (ex_out_o),
        .wb_we_i   (wb_we_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i),
        .rs1_fwd_o (rs1_fwd),
        .rs2_fwd_o (rs2_fwd),
        .alu_a_o   (alu_a),
        .alu_b_o   (alu_b)
    );

    alu_decoder u_alu_decoder (
        .alu_op_i   (ex_in_i.alu_op),
        .funct3_i   (ex_in_i.funct3),
        .bit30_i    (ex_in_i.bit30),
        .alu_ctrl_o (alu_ctrl)
    );

    alu u_alu (
        .a_i        (alu_a),
        .b_i        (alu_b),
        .alu_ctrl_i (alu_ctrl),
        .result_o   (alu_result)
    );

    // address offset comes from the computed effective address
    store_align u_store_align (
        .store_i      (ex_in_i.store),
        .funct3_i     (ex_in_i.funct3),
        .offset_i     (alu_result[1:0]),
        .rs2_i        (rs2_fwd),
        .byte_en_o    (byte_en),
        .store_data_o (store_data),
        .misaligned_o (misaligned)
    );

    assign csr_wr = ex_in_i.valid && ex_in_i.csr_we;

    csr_file u_csr_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (csr_wr),
        .addr_i   (ex_in_i.csr_addr),
        .funct3_i (ex_in_i.funct3),
        .rs1_i    (rs1_fwd),
        .uimm_i   (ex_in_i.imm),
        .rdata_o  (csr_rdata)
    );

    always_comb begin
        ex_next.valid            = ex_in_i.valid;
        ex_next.result           = (ex_in_i.wr_sel == WR_CSR) ? csr_rdata : alu_result;
        ex_next.store_data       = store_data;
        // nothing leaves an invalid slot enabled
        ex_next.byte_en          = ex_in_i.valid ? byte_en : 4'b0000;
        ex_next.store_misaligned = ex_in_i.valid && ex_in_i.store && misaligned;
        ex_next.rd_addr          = ex_in_i.rd_addr;
        ex_next.rd_we            = ex_in_i.valid && ex_in_i.rd_we;
        ex_next.wr_sel           = ex_in_i.wr_sel;
        ex_next.pc_plus4         = ex_in_i.pc_plus4;
    end

    // ex/mem register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_out_o <= '0;
        end else begin
            ex_out_o <= ex_next;
        end
    end

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/100ps

module csr_file (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      we_i,
    input  logic [ex_pkg::CSR_AW-1:0] addr_i,
    input  logic [2:0]                funct3_i,
    input  logic [ex_pkg::XLEN-1:0]   rs1_i,
    input  logic [ex_pkg::XLEN-1:0]   uimm_i,
    output logic [ex_pkg::XLEN-1:0]   rdata_o
);
    import ex_pkg::*;

    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] wdata;
    logic            wr_en;

    always_comb begin
        case (funct3_i)
            F3_CSRRW:  wdata = rs1_i;
            F3_CSRRWI: wdata = uimm_i;
            default:   wdata = '0;
        endcase
    end

    assign wr_en = we_i && ((funct3_i == F3_CSRRW) || (funct3_i == F3_CSRRWI));

    // old value, before the write at this edge
    always_comb begin
        case (addr_i)
            CSR_MTVEC:    rdata_o = mtvec_q;
            CSR_MSCRATCH: rdata_o = mscratch_q;
            CSR_MEPC:     rdata_o = mepc_q;
            default:      rdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
        end else if (wr_en) begin
            case (addr_i)
                CSR_MTVEC:    mtvec_q    <= wdata;
                CSR_MSCRATCH: mscratch_q <= wdata;
                CSR_MEPC:     mepc_q     <= wdata;
                // unknown address, write dropped
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== logic/store_align.sv ====
`timescale 1ns/100ps

module store_align (
    input  logic                    store_i,
    input  logic [2:0]              funct3_i,
    input  logic [1:0]              offset_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    output logic [3:0]              byte_en_o,
    output logic [ex_pkg::XLEN-1:0] store_data_o,
    output logic                    misaligned_o
);
    import ex_pkg::*;

    always_comb begin
        byte_en_o    = 4'b0000;
        store_data_o = rs2_i;
        misaligned_o = 1'b0;
        if (store_i) begin
            case (funct3_i)
                F3_SB: begin
                    byte_en_o    = 4'b0001 << offset_i;
                    store_data_o = {4{rs2_i[7:0]}};
                end
                F3_SH: begin
                    store_data_o = {2{rs2_i[15:0]}};
                    if (offset_i[0])
                        misaligned_o = 1'b1;
                    else
                        byte_en_o = offset_i[1] ? 4'b1100 : 4'b0011;
                end
                F3_SW: begin
                    if (offset_i != 2'b00)
                        misaligned_o = 1'b1;
                    else
                        byte_en_o = 4'b1111;
                end
                // unsupported width, no lanes
                default: begin
                    byte_en_o = 4'b0000;
                end
            endcase
        end
    end

endmodule

// ==== logic/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
    input  ex_pkg::ex_in_t            ex_in_i,
    input  ex_pkg::ex_out_t           exmem_i,
    input  logic                      wb_we_i,
    input  logic [ex_pkg::REG_AW-1:0] wb_addr_i,
    input  logic [ex_pkg::XLEN-1:0]   wb_data_i,
    output logic [ex_pkg::XLEN-1:0]   rs1_fwd_o,
    output logic [ex_pkg::XLEN-1:0]   rs2_fwd_o,
    output logic [ex_pkg::XLEN-1:0]   alu_a_o,
    output logic [ex_pkg::XLEN-1:0]   alu_b_o
);
    import ex_pkg::*;

    function automatic fwd_sel_t pick_src(
        input logic [REG_AW-1:0] src,
        input logic              exmem_ok,
        input logic [REG_AW-1:0] exmem_rd,
        input logic              wb_we,
        input logic [REG_AW-1:0] wb_rd
    );
        fwd_sel_t sel;
        sel = FWD_REG;
        // x0 always reads the register file
        if (src == '0)
            sel = FWD_REG;
        else if (exmem_ok && (src == exmem_rd))
            sel = FWD_EXMEM;
        else if (wb_we && (src == wb_rd))
            sel = FWD_WB;
        return sel;
    endfunction

    function automatic logic [XLEN-1:0] fwd_value(
        input fwd_sel_t          sel,
        input logic [XLEN-1:0]   reg_val,
        input logic [XLEN-1:0]   exmem_val,
        input logic [XLEN-1:0]   wb_val
    );
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_WB:    return wb_val;
            default:   return reg_val;
        endcase
    endfunction

    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    logic     exmem_ok;

    // load data is not ready yet in ex/mem
    assign exmem_ok = exmem_i.valid && exmem_i.rd_we && (exmem_i.wr_sel != WR_MEM);

    assign rs1_sel = pick_src(ex_in_i.rs1_addr, exmem_ok, exmem_i.rd_addr, wb_we_i, wb_addr_i);
    assign rs2_sel = pick_src(ex_in_i.rs2_addr, exmem_ok, exmem_i.rd_addr, wb_we_i, wb_addr_i);

    assign rs1_fwd_o = fwd_value(rs1_sel, ex_in_i.rs1_data, exmem_i.result, wb_data_i);
    assign rs2_fwd_o = fwd_value(rs2_sel, ex_in_i.rs2_data, exmem_i.result, wb_data_i);

    assign alu_a_o = ex_in_i.a_is_pc ? ex_in_i.pc : rs1_fwd_o;
    assign alu_b_o = ex_in_i.b_is_imm ? ex_in_i.imm : rs2_fwd_o;

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic [ex_pkg::XLEN-1:0] a_i,
    input  logic [ex_pkg::XLEN-1:0] b_i,
    input  ex_pkg::alu_ctrl_t       alu_ctrl_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (alu_ctrl_i)
            CTRL_ADD:    result_o = a_i + b_i;
            CTRL_SUB:    result_o = a_i - b_i;
            CTRL_SLL:    result_o = a_i << shamt;
            CTRL_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_s};
            CTRL_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_u};
            CTRL_XOR:    result_o = a_i ^ b_i;
            CTRL_SRL:    result_o = a_i >> shamt;
            // sign bit fills from the left
            CTRL_SRA:    result_o = $signed(a_i) >>> shamt;
            CTRL_OR:     result_o = a_i | b_i;
            CTRL_AND:    result_o = a_i & b_i;
            CTRL_PASS_B: result_o = b_i;
            default:     result_o = '0;
        endcase
    end

endmodule

// ==== logic/alu_decoder.sv ====
`timescale 1ns/100ps

module alu_decoder (
    input  ex_pkg::alu_op_t   alu_op_i,
    input  logic [2:0]        funct3_i,
    input  logic              bit30_i,
    output ex_pkg::alu_ctrl_t alu_ctrl_o
);
    import ex_pkg::*;

    logic sub_en;

    // only R-type may subtract, addi ignores bit 30
    assign sub_en = bit30_i && (alu_op_i == ALU_REG);

    always_comb begin
        alu_ctrl_o = CTRL_ADD;
        case (alu_op_i)
            ALU_ADD: begin
                alu_ctrl_o = CTRL_ADD;
            end
            ALU_PASS_B: begin
                alu_ctrl_o = CTRL_PASS_B;
            end
            ALU_REG, ALU_IMM: begin
                case (funct3_i)
                    3'b000: alu_ctrl_o = sub_en ? CTRL_SUB : CTRL_ADD;
                    3'b001: alu_ctrl_o = CTRL_SLL;
                    3'b010: alu_ctrl_o = CTRL_SLT;
                    3'b011: alu_ctrl_o = CTRL_SLTU;
                    3'b100: alu_ctrl_o = CTRL_XOR;
                    // srai and sra both carry bit 30
                    3'b101: alu_ctrl_o = bit30_i ? CTRL_SRA : CTRL_SRL;
                    3'b110: alu_ctrl_o = CTRL_OR;
                    default: alu_ctrl_o = CTRL_AND;
                endcase
            end
            default: begin
                alu_ctrl_o = CTRL_ADD;
            end
        endcase
    end

endmodule

// ==== logic/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int CSR_AW = 12;

    // machine CSRs kept by this stage
    localparam logic [CSR_AW-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_AW-1:0] CSR_MEPC     = 12'h341;

    // store widths
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // csr ops
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRWI = 3'b101;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'b00,
        ALU_REG    = 2'b01,
        ALU_IMM    = 2'b10,
        ALU_PASS_B = 2'b11
    } alu_op_t;

    typedef enum logic [3:0] {
        CTRL_ADD,
        CTRL_SUB,
        CTRL_SLL,
        CTRL_SLT,
        CTRL_SLTU,
        CTRL_XOR,
        CTRL_SRL,
        CTRL_SRA,
        CTRL_OR,
        CTRL_AND,
        CTRL_PASS_B
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        WR_ALU = 2'b00,
        WR_MEM = 2'b01,
        WR_PC4 = 2'b10,
        WR_CSR = 2'b11
    } wr_sel_t;

    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,
        FWD_EXMEM = 2'b01,
        FWD_WB    = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_plus4;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rs1_addr;
        logic [REG_AW-1:0] rs2_addr;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   imm;
        logic [CSR_AW-1:0] csr_addr;
        logic [2:0]        funct3;
        logic              bit30;
        alu_op_t           alu_op;
        logic              a_is_pc;
        logic              b_is_imm;
        logic              store;
        logic              csr_we;
        logic              rd_we;
        wr_sel_t           wr_sel;
    } ex_in_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   store_data;
        logic [3:0]        byte_en;
        logic              store_misaligned;
        logic [REG_AW-1:0] rd_addr;
        logic              rd_we;
        wr_sel_t           wr_sel;
        logic [XLEN-1:0]   pc_plus4;
    } ex_out_t;

endpackage
